/* compile.f */
time_pkg.sv
stopwatch_pkg.sv
timer_view_if.sv
time_counter.sv
timer_channel.sv
display_select.sv
stopwatch_top.sv
tb_stopwatch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the stopwatch testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_stopwatch_sim

verilator --binary --timing -f compile.f --top-module tb_stopwatch -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* tb_stopwatch.sv */
// ############################
// Random strobes from a fixed-seed LCG, checked every cycle against a model
// Stops at the first mismatch; the run ends once both lap stores have overflowed
// ############################
`timescale 1ns/1ns
`default_nettype none

module tb_stopwatch
    import time_pkg::*, stopwatch_pkg::*;
();

    localparam int RESET_LIMIT = 20;
    localparam int MIN_CYCLES  = 6000;
    localparam int RUN_LIMIT   = 50000;

    logic        clk_1kHz;
    logic        rst;
    logic        start;
    logic        stop;
    logic        lap;
    logic        timer_sel;
    logic        view_sel;
    logic [3:0]  lap_view;
    logic [7:0]  hours;
    logic [7:0]  minutes;
    logic [7:0]  seconds;
    logic [9:0]  millisec;
    logic        stopped;
    logic [3:0]  lap_count;
    time_t       dut_time;

    // Reference model of both channels
    timer_state_t m_state [2];
    time_t        m_time [2];
    lap_cnt_t     m_cnt [2];
    time_t        m_laps [2][LAP_DEPTH];
    logic         full_seen [2];
    logic [31:0]  seed;

    stopwatch_top UUT (
        .clk_1kHz  (clk_1kHz),
        .rst       (rst),
        .start     (start),
        .stop      (stop),
        .lap       (lap),
        .timer_sel (timer_sel),
        .view_sel  (view_sel),
        .lap_view  (lap_view),
        .hours     (hours),
        .minutes   (minutes),
        .seconds   (seconds),
        .millisec  (millisec),
        .stopped   (stopped),
        .lap_count (lap_count)
    );

    assign dut_time = {hours, minutes, seconds, millisec};

    initial begin
        clk_1kHz = 1'b0;
        forever #2 clk_1kHz = ~clk_1kHz;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk_1kHz);
        @(negedge clk_1kHz);
        rst = 1'b0;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Next time through a total millisecond count, wrapping after 99 hours
    function automatic time_t next_time(input time_t t);
        int    total;
        time_t n;
        total = ((int'(t.hours) * 60 + int'(t.minutes)) * 60 + int'(t.seconds)) * 1000;
        total = total + int'(t.millisec) + 1;
        total = total % ((int'(HOUR_MAX) + 1) * 3600000);
        n.millisec = MS_W'(total % 1000);
        n.seconds  = SEC_W'((total / 1000) % 60);
        n.minutes  = MIN_W'((total / 60000) % 60);
        n.hours    = HOUR_W'(total / 3600000);
        return n;
    endfunction

    task automatic check_time(input string name, input time_t got, input time_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input lap_cnt_t got, input lap_cnt_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_outputs();
        time_t exp_time;
        if (view_sel && (lap_view < m_cnt[timer_sel])) begin
            exp_time = m_laps[timer_sel][lap_view];
        end else begin
            exp_time = m_time[timer_sel];
        end
        check_time("disp_time", dut_time, exp_time);
        check_count("lap_count", lap_count, m_cnt[timer_sel]);
        check_flag("stopped", stopped, m_state[timer_sel] == STOPPED);
    endtask

    // Strobes are rare, selects change only now and then
    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = lcg_next();
        r2 = lcg_next();
        start = (r1[31:28] == 4'd0);
        stop  = (r1[27:23] == 5'd0);
        lap   = (r1[19:17] == 3'd0);
        if (r2[31:25] == 7'd0) timer_sel = ~timer_sel;
        if (r2[24:20] == 5'd0) view_sel = ~view_sel;
        if (r2[19:16] == 4'd0) lap_view = r2[29:26];
    endtask

    task automatic store_lap(input int c);
        if (m_cnt[c] < lap_cnt_t'(LAP_DEPTH)) begin
            m_laps[c][int'(m_cnt[c])] = m_time[c];
            m_cnt[c] = m_cnt[c] + 1'b1;
        end else begin
            full_seen[c] = 1'b1;
        end
    endtask

    // Predicts the state after the coming rising edge
    task automatic model_step();
        for (int c = 0; c < 2; c++) begin
            if (timer_sel == c[0]) begin
                case (m_state[c])
                    IDLE: begin
                        if (start) begin
                            m_state[c] = RUNNING;
                            m_cnt[c] = '0;
                        end
                    end
                    RUNNING: begin
                        if (stop) m_state[c] = STOPPED;
                        else if (lap) store_lap(c);
                        m_time[c] = next_time(m_time[c]);
                    end
                    default: begin
                        if (start) m_state[c] = RUNNING;
                        else if (lap) store_lap(c);
                    end
                endcase
            end
        end
    endtask

    initial begin
        int cycle;
        int wait_cycles;
        seed      = 32'h5d1a;
        start     = 1'b0;
        stop      = 1'b0;
        lap       = 1'b0;
        timer_sel = 1'b0;
        view_sel  = 1'b0;
        lap_view  = 4'd0;
        for (int c = 0; c < 2; c++) begin
            m_state[c]   = IDLE;
            m_time[c]    = '0;
            m_cnt[c]     = '0;
            full_seen[c] = 1'b0;
            for (int i = 0; i < LAP_DEPTH; i++) begin
                m_laps[c][i] = '0;
            end
        end

        wait_cycles = 0;
        @(posedge clk_1kHz);
        while (rst) begin
            if (wait_cycles >= RESET_LIMIT) begin
                $display("Reset was not released within %0d cycles", RESET_LIMIT);
                $display("Checks failed");
                $fatal(1);
            end else begin
                @(posedge clk_1kHz);
                wait_cycles++;
            end
        end

        cycle = 0;
        while (!((cycle >= MIN_CYCLES) && full_seen[0] && full_seen[1])) begin
            if (cycle >= RUN_LIMIT) begin
                $display("Lap stores did not both overflow within %0d cycles", RUN_LIMIT);
                $display("Checks failed");
                $fatal(1);
            end else begin
                @(negedge clk_1kHz);
                check_outputs();
                drive_random();
                model_step();
                cycle++;
            end
        end
        @(negedge clk_1kHz);
        check_outputs();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* stopwatch_top.sv */
// ############################
// Two-timer stopwatch, one count step per clk_1kHz cycle
// start, stop and lap are one-cycle strobes for the selected timer
// ############################
`timescale 1ns/1ns
`default_nettype none

module stopwatch_top
    import time_pkg::*;
(
    input  logic              clk_1kHz,
    input  logic              rst,
    input  logic              start,
    input  logic              stop,
    input  logic              lap,
    input  logic              timer_sel,
    input  logic              view_sel,
    input  logic [3:0]        lap_view,
    output logic [HOUR_W-1:0] hours,
    output logic [MIN_W-1:0]  minutes,
    output logic [SEC_W-1:0]  seconds,
    output logic [MS_W-1:0]   millisec,
    output logic              stopped,
    output logic [3:0]        lap_count
);

    time_t disp_time;

    timer_view_if view0 ();
    timer_view_if view1 ();

    // Only the selected channel sees active high
    timer_channel u_ch0 (
        .clk_1kHz (clk_1kHz),
        .rst      (rst),
        .active   (~timer_sel),
        .start    (start),
        .stop     (stop),
        .lap      (lap),
        .view     (view0.channel)
    );

    timer_channel u_ch1 (
        .clk_1kHz (clk_1kHz),
        .rst      (rst),
        .active   (timer_sel),
        .start    (start),
        .stop     (stop),
        .lap      (lap),
        .view     (view1.channel)
    );

    display_select u_disp (
        .timer_sel (timer_sel),
        .view_sel  (view_sel),
        .lap_view  (lap_view),
        .ch0       (view0.display),
        .ch1       (view1.display),
        .disp_time (disp_time),
        .lap_count (lap_count),
        .stopped   (stopped)
    );

    assign hours    = disp_time.hours;
    assign minutes  = disp_time.minutes;
    assign seconds  = disp_time.seconds;
    assign millisec = disp_time.millisec;

endmodule

`default_nettype wire

/* display_select.sv */
// ############################
// Purely combinational, zero-cycle selection
// Lap view falls back to live time past the stored laps
// ############################
`timescale 1ns/1ns
`default_nettype none

module display_select
    import time_pkg::*, stopwatch_pkg::*;
(
    input  logic         timer_sel,
    input  logic         view_sel,
    input  lap_idx_t     lap_view,
    timer_view_if.display ch0,
    timer_view_if.display ch1,
    output time_t        disp_time,
    output lap_cnt_t     lap_count,
    output logic         stopped
);

    time_t    sel_cur;
    time_t    sel_lap;
    lap_cnt_t sel_count;
    logic     sel_stopped;
    logic     show_lap;

    // Both stores are addressed, only the selected one is shown
    assign ch0.lap_addr = lap_view;
    assign ch1.lap_addr = lap_view;

    // timer_sel low picks channel 0
    assign sel_cur     = timer_sel ? ch1.cur_time  : ch0.cur_time;
    assign sel_lap     = timer_sel ? ch1.lap_time  : ch0.lap_time;
    assign sel_count   = timer_sel ? ch1.lap_count : ch0.lap_count;
    assign sel_stopped = timer_sel ? ch1.stopped   : ch0.stopped;

    assign show_lap = view_sel && (lap_view < sel_count);

    assign disp_time = show_lap ? sel_lap : sel_cur;
    assign lap_count = sel_count;
    assign stopped   = sel_stopped;

endmodule

`default_nettype wire

/* timer_channel.sv */
// ############################
// One timer: control FSM, lap counter and ten-entry lap store
// Acts only on cycles with active high, otherwise frozen
// ############################
`timescale 1ns/1ns
`default_nettype none

module timer_channel
    import time_pkg::*, stopwatch_pkg::*;
(
    input  logic         clk_1kHz,
    input  logic         rst,
    input  logic         active,
    input  logic         start,
    input  logic         stop,
    input  logic         lap,
    timer_view_if.channel view
);

    timer_state_t state;
    lap_cnt_t     lap_count;
    time_t        laps [LAP_DEPTH];
    time_t        cur_time;

    logic advance;
    logic leave_idle;
    logic room;
    logic lap_wr;

    // Counter steps on every active RUNNING cycle, the stop cycle included
    assign advance    = active && (state == RUNNING);
    assign leave_idle = active && (state == IDLE) && start;
    assign room       = (lap_count < LAP_DEPTH);

    // stop wins over lap while running, start wins over lap while stopped
    assign lap_wr = active && lap && room &&
                    (((state == RUNNING) && !stop) || ((state == STOPPED) && !start));

    time_counter u_counter (
        .clk_1kHz (clk_1kHz),
        .rst      (rst),
        .advance  (advance),
        .value    (cur_time)
    );

    always_ff @(posedge clk_1kHz or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else if (active) begin
            case (state)
                IDLE:    if (start) state <= RUNNING;
                RUNNING: if (stop) state <= STOPPED;
                STOPPED: if (start) state <= RUNNING;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_1kHz or posedge rst) begin
        if (rst) begin
            lap_count <= '0;
        end else if (leave_idle) begin
            lap_count <= '0;
        end else if (lap_wr) begin
            lap_count <= lap_count + 1'b1;
        end
    end

    // Records hold the time from before this cycle's step
    always_ff @(posedge clk_1kHz or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < LAP_DEPTH; i++) begin
                laps[i] <= '0;
            end
        end else if (lap_wr) begin
            laps[lap_count] <= cur_time;
        end
    end

    assign view.cur_time  = cur_time;
    assign view.lap_count = lap_count;
    assign view.stopped   = (state == STOPPED);

    // Out of range addresses read as zero
    always_comb begin
        if (view.lap_addr < LAP_DEPTH) begin
            view.lap_time = laps[view.lap_addr];
        end else begin
            view.lap_time = '0;
        end
    end

    a_lap_count_max: assert property (
        @(posedge clk_1kHz) disable iff (rst)
        lap_count <= LAP_DEPTH
    ) else $error("lap count above store depth");

    a_frozen_time: assert property (
        @(posedge clk_1kHz) disable iff (rst)
        !(active && (state == RUNNING)) |=> $stable(cur_time)
    ) else $error("time moved while channel was not running");

endmodule

`default_nettype wire

/* time_counter.sv */
// ############################
// Up-counter, one millisecond per cycle with advance high
// Wraps from 99:59:59.999 to zero
// ############################
`timescale 1ns/1ns
`default_nettype none

module time_counter
    import time_pkg::*;
(
    input  logic  clk_1kHz,
    input  logic  rst,
    input  logic  advance,
    output time_t value
);

    logic ms_last;
    logic sec_last;
    logic min_last;
    logic hour_last;

    assign ms_last   = (value.millisec == MS_MAX);
    assign sec_last  = (value.seconds == SEC_MAX);
    assign min_last  = (value.minutes == MIN_MAX);
    assign hour_last = (value.hours == HOUR_MAX);

    // Carry ripples upward only when every lower field is at its limit
    always_ff @(posedge clk_1kHz or posedge rst) begin
        if (rst) begin
            value <= '0;
        end else if (advance) begin
            if (!ms_last) begin
                value.millisec <= value.millisec + 1'b1;
            end else begin
                value.millisec <= '0;
                if (!sec_last) begin
                    value.seconds <= value.seconds + 1'b1;
                end else begin
                    value.seconds <= '0;
                    if (!min_last) begin
                        value.minutes <= value.minutes + 1'b1;
                    end else begin
                        value.minutes <= '0;
                        if (!hour_last) begin
                            value.hours <= value.hours + 1'b1;
                        end else begin
                            value.hours <= '0;
                        end
                    end
                end
            end
        end
    end

    a_fields_in_range: assert property (
        @(posedge clk_1kHz) disable iff (rst)
        (value.millisec <= MS_MAX) && (value.seconds <= SEC_MAX) &&
        (value.minutes <= MIN_MAX) && (value.hours <= HOUR_MAX)
    ) else $error("time field beyond its wrap limit");

endmodule

`default_nettype wire

/* timer_view_if.sv */
// ############################
// One channel's view towards the display selector
// All signals are levels, valid every cycle, no handshake
// ############################
`timescale 1ns/1ns
`default_nettype none

interface timer_view_if
    import time_pkg::*, stopwatch_pkg::*;
();

    time_t    cur_time;
    time_t    lap_time;
    lap_cnt_t lap_count;
    logic     stopped;
    // Read address into the lap store, lap_time follows it combinationally
    lap_idx_t lap_addr;

    modport channel (
        output cur_time, lap_time, lap_count, stopped,
        input  lap_addr
    );

    modport display (
        input  cur_time, lap_time, lap_count, stopped,
        output lap_addr
    );

endinterface

`default_nettype wire

/* stopwatch_pkg.sv */
// ############################
// Timer control encoding and lap store sizing
// Lap addresses 10 to 15 are legal and read back as zero
// ############################
`default_nettype none

package stopwatch_pkg;

    // Timer control states
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        RUNNING = 2'b01,
        STOPPED = 2'b10
    } timer_state_t;

    // Records kept per timer
    localparam int LAP_DEPTH = 10;

    // Wide enough for addresses 0..9 and counts 0..10
    localparam int LAP_IDX_W = $clog2(LAP_DEPTH);

    typedef logic [LAP_IDX_W-1:0] lap_idx_t;
    typedef logic [LAP_IDX_W-1:0] lap_cnt_t;

endpackage

`default_nettype wire

/* time_pkg.sv */
// ############################
// Time record shared by counter, channels and display
// Fields are binary, not BCD; hours run 0 to 99 then wrap
// ############################
`default_nettype none

package time_pkg;

    // Field widths
    localparam int HOUR_W = 8;
    localparam int MIN_W  = 8;
    localparam int SEC_W  = 8;
    localparam int MS_W   = 10;

    // Last value of each field before it wraps to zero
    localparam logic [HOUR_W-1:0] HOUR_MAX = 8'd99;
    localparam logic [MIN_W-1:0]  MIN_MAX  = 8'd59;
    localparam logic [SEC_W-1:0]  SEC_MAX  = 8'd59;
    localparam logic [MS_W-1:0]   MS_MAX   = 10'd999;

    // 34-bit record, hours in the top bits
    typedef struct packed {
        logic [HOUR_W-1:0] hours;
        logic [MIN_W-1:0]  minutes;
        logic [SEC_W-1:0]  seconds;
        logic [MS_W-1:0]   millisec;
    } time_t;

endpackage

`default_nettype wire
